// File: decode_unit.sv
// Decode stage
// Maps the opcode to an ALU operation, extracts the immediate and
// registers the operands into the decode/execute bundle
`timescale 1ns/10ps
`default_nettype none

module decode_unit
(
	input logic clk,
	input logic i_rst,
	input logic i_valid,
	input lc3b_pkg::word_t i_ir,
	input lc3b_pkg::word_t i_pc,
	output lc3b_pkg::reg_idx_t o_src1,
	output lc3b_pkg::reg_idx_t o_src2,
	input lc3b_pkg::word_t i_sr1_val,
	input lc3b_pkg::word_t i_sr2_val,
	issue_if.src issue
);
	import lc3b_pkg::*;

	opcode_t opcode;
	alu_op_t alu_op;
	word_t imm;
	logic imm_sel;
	logic set_cc;
	logic supported;

	assign opcode = opcode_t'(i_ir[15:12]);

	assign o_src1 = i_ir[8:6];
	assign o_src2 = i_ir[2:0];

	always_comb
	begin
		alu_op = alu_add;
		imm = {{11{i_ir[4]}}, i_ir[4:0]};
		imm_sel = 1'b0;
		set_cc = 1'b1;
		supported = 1'b1;
		case (opcode)
			op_add:
			begin
				alu_op = alu_add;
				imm_sel = i_ir[5];
			end
			op_and:
			begin
				alu_op = alu_and;
				imm_sel = i_ir[5];
			end
			op_not:
				alu_op = alu_not;
			op_shf:
			begin
				// IR[4] picks the direction and IR[5] the arithmetic right shift
				if (!i_ir[4])
					alu_op = alu_lshf;
				else if (i_ir[5])
					alu_op = alu_rshfa;
				else
					alu_op = alu_rshfl;
				imm = {12'b0, i_ir[3:0]};
				imm_sel = 1'b1;
			end
			op_lea:
			begin
				alu_op = alu_pass;
				imm = {{6{i_ir[8]}}, i_ir[8:0], 1'b0};
				imm_sel = 1'b1;
				set_cc = 1'b0;
			end
			default:
			begin
				set_cc = 1'b0;
				supported = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
			issue.valid <= 1'b0;
		else
			issue.valid <= i_valid & supported;
	end

	always_ff @(posedge clk)
	begin
		issue.alu_op <= alu_op;
		issue.dest <= i_ir[11:9];
		issue.src1 <= o_src1;
		issue.src2 <= o_src2;
		issue.sr1_val <= i_sr1_val;
		issue.sr2_val <= i_sr2_val;
		issue.imm <= imm;
		issue.imm_sel <= imm_sel;
		issue.pc <= i_pc;
		issue.set_cc <= set_cc;
	end

endmodule : decode_unit

`default_nettype wire

// File: execute_unit.sv
// Execute stage
// Forwards from the execute/writeback register, runs the ALU, the
// shifter or the LEA adder and registers the result for writeback
`timescale 1ns/10ps
`default_nettype none

module execute_unit
(
	input logic clk,
	input logic i_rst,
	issue_if.dst issue,
	wb_if.src wb
);
	import lc3b_pkg::*;

	word_t op_a;
	word_t reg_b;
	word_t op_b;
	word_t lea_addr;
	word_t result;
	logic fwd_a;
	logic fwd_b;
	logic [3:0] shamt;

	// Previous result is still in flight to the register file
	assign fwd_a = wb.valid && (wb.dest == issue.src1);
	assign fwd_b = wb.valid && (wb.dest == issue.src2) && !issue.imm_sel;

	assign op_a = fwd_a ? wb.data : issue.sr1_val;
	assign reg_b = fwd_b ? wb.data : issue.sr2_val;
	assign op_b = issue.imm_sel ? issue.imm : reg_b;

	assign shamt = issue.imm[3:0];

	// pc already points past the instruction
	assign lea_addr = issue.pc + issue.imm;

	always_comb
	begin
		case (issue.alu_op)
			alu_add:
				result = op_a + op_b;
			alu_and:
				result = op_a & op_b;
			alu_not:
				result = ~op_a;
			alu_lshf:
				result = op_a << shamt;
			alu_rshfl:
				result = op_a >> shamt;
			alu_rshfa:
				result = word_t'($signed(op_a) >>> shamt);
			alu_pass:
				result = lea_addr;
			default:
				result = op_a;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
			wb.valid <= 1'b0;
		else
			wb.valid <= issue.valid;
	end

	always_ff @(posedge clk)
	begin
		wb.dest <= issue.dest;
		wb.data <= result;
		wb.set_cc <= issue.set_cc;
	end

endmodule : execute_unit

`default_nettype wire

// File: fetch_unit.sv
// Fetch stage
// Holds the PC and drives the instruction port; on a response the
// instruction and its next address go into the fetch/decode register
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
(
	input logic clk,
	input logic i_rst,
	input logic i_imem_resp,
	input lc3b_pkg::word_t i_imem_rdata,
	output lc3b_pkg::word_t o_imem_addr,
	output logic o_imem_read,
	output logic o_valid,
	output lc3b_pkg::word_t o_ir,
	output lc3b_pkg::word_t o_pc
);
	import lc3b_pkg::*;

	word_t pc;
	word_t pc_next;
	logic read_en;
	logic accept;

	assign pc_next = pc + PC_STEP;

	// Only a response to an issued read counts
	assign accept = read_en & i_imem_resp;

	assign o_imem_addr = pc;
	assign o_imem_read = read_en;

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			pc <= RESET_PC;
			read_en <= 1'b0;
			o_valid <= 1'b0;
		end
		else
		begin
			read_en <= 1'b1;
			// No response means a bubble into decode
			o_valid <= accept;
			if (accept)
				pc <= pc_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			o_ir <= i_imem_rdata;
			o_pc <= pc_next;
		end
	end

endmodule : fetch_unit

`default_nettype wire

// File: lc3b_pipe.sv
// LC-3b integer pipeline top
// Fetch, decode, execute and the register file, with the instruction
// port and the writeback result brought out as plain ports
`timescale 1ns/10ps
`default_nettype none

module lc3b_pipe
(
	input logic clk,
	input logic i_rst,
	input logic i_imem_resp,
	input lc3b_pkg::word_t i_imem_rdata,
	output lc3b_pkg::word_t o_imem_addr,
	output logic o_imem_read,
	output logic o_wb_valid,
	output lc3b_pkg::reg_idx_t o_wb_dest,
	output lc3b_pkg::word_t o_wb_data,
	output lc3b_pkg::cc_t o_cc
);
	import lc3b_pkg::*;

	logic fd_valid;
	word_t fd_ir;
	word_t fd_pc;
	reg_idx_t src1;
	reg_idx_t src2;
	word_t sr1_val;
	word_t sr2_val;

	issue_if issue ();
	wb_if wb ();

	fetch_unit fetch_unit_inst
	(
		.clk,
		.i_rst,
		.i_imem_resp,
		.i_imem_rdata,
		.o_imem_addr,
		.o_imem_read,
		.o_valid(fd_valid),
		.o_ir(fd_ir),
		.o_pc(fd_pc)
	);

	decode_unit decode_unit_inst
	(
		.clk,
		.i_rst,
		.i_valid(fd_valid),
		.i_ir(fd_ir),
		.i_pc(fd_pc),
		.o_src1(src1),
		.o_src2(src2),
		.i_sr1_val(sr1_val),
		.i_sr2_val(sr2_val),
		.issue(issue.src)
	);

	reg_file reg_file_inst
	(
		.clk,
		.i_rst,
		.wb(wb.dst),
		.i_src1(src1),
		.i_src2(src2),
		.o_sr1_val(sr1_val),
		.o_sr2_val(sr2_val),
		.o_cc
	);

	execute_unit execute_unit_inst
	(
		.clk,
		.i_rst,
		.issue(issue.dst),
		.wb(wb.src)
	);

	assign o_wb_valid = wb.valid;
	assign o_wb_dest = wb.dest;
	assign o_wb_data = wb.data;

endmodule : lc3b_pipe

`default_nettype wire

// File: lc3b_pipe_assert.sv
// Port assertions for the LC-3b pipeline
// Reset behaviour, fetch alignment, cc encoding and writeback values
`timescale 1ns/10ps
`default_nettype none

module lc3b_pipe_assert
(
	input logic clk,
	input logic i_rst,
	input lc3b_pkg::word_t o_imem_addr,
	input logic o_wb_valid,
	input lc3b_pkg::reg_idx_t o_wb_dest,
	input lc3b_pkg::word_t o_wb_data,
	input lc3b_pkg::cc_t o_cc
);
	import lc3b_pkg::*;

	int fail_count = 0;

	// Valid is cleared by the reset edge
	no_wb_in_reset: assert property (@(posedge clk) i_rst |=> !o_wb_valid)
		else
		begin
			fail_count++;
			$error("writeback valid during reset");
		end

	addr_even: assert property (@(posedge clk) disable iff (i_rst) !o_imem_addr[0])
		else
		begin
			fail_count++;
			$error("odd instruction address");
		end

	cc_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot(o_cc))
		else
		begin
			fail_count++;
			$error("condition code not one-hot");
		end

	wb_known: assert property (@(posedge clk) disable iff (i_rst)
		o_wb_valid |-> !$isunknown({o_wb_dest, o_wb_data}))
		else
		begin
			fail_count++;
			$error("unknown writeback dest or data");
		end

endmodule : lc3b_pipe_assert

`default_nettype wire

// File: lc3b_pkg.sv
// LC-3b core package
// Word, register and cc types, opcode and ALU-operation encodings,
// reset values for the integer pipeline
`default_nettype none

package lc3b_pkg;

	localparam int WORD_W = 16;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [2:0] reg_idx_t;

	// One-hot N Z P flags
	typedef logic [2:0] cc_t;

	localparam cc_t CC_N = 3'b100;
	localparam cc_t CC_Z = 3'b010;
	localparam cc_t CC_P = 3'b001;

	localparam word_t RESET_PC = 16'h0000;
	localparam cc_t CC_RESET = CC_Z;
	localparam word_t PC_STEP = 16'd2;

	// Full LC-3b opcode map of which only a few execute here
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_t;

	typedef enum logic [2:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_lshf,
		alu_rshfl,
		alu_rshfa,
		alu_pass
	} alu_op_t;

endpackage : lc3b_pkg

`default_nettype wire

// File: list.f
lc3b_pkg.sv
pipe_if.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
lc3b_pipe.sv
lc3b_pipe_assert.sv
tb_lc3b_pipe.sv

// File: pipe_if.sv
// Pipeline bundles
// issue_if carries a decoded instruction into execute,
// wb_if carries the execute result back to the register file
`timescale 1ns/10ps
`default_nettype none

interface issue_if;
	import lc3b_pkg::*;

	logic valid;
	alu_op_t alu_op;
	reg_idx_t dest;
	reg_idx_t src1;
	reg_idx_t src2;
	word_t sr1_val;
	word_t sr2_val;
	word_t imm;
	logic imm_sel;
	word_t pc;
	logic set_cc;

	modport src (output valid, alu_op, dest, src1, src2, sr1_val, sr2_val,
		imm, imm_sel, pc, set_cc);
	modport dst (input valid, alu_op, dest, src1, src2, sr1_val, sr2_val,
		imm, imm_sel, pc, set_cc);
endinterface : issue_if

interface wb_if;
	import lc3b_pkg::*;

	logic valid;
	reg_idx_t dest;
	word_t data;
	logic set_cc;

	modport src (output valid, dest, data, set_cc);
	modport dst (input valid, dest, data, set_cc);
endinterface : wb_if

`default_nettype wire

// File: reg_file.sv
// Register file
// Eight general registers plus the condition codes, written from
// writeback; reads see a same-cycle write
`timescale 1ns/10ps
`default_nettype none

module reg_file
(
	input logic clk,
	input logic i_rst,
	wb_if.dst wb,
	input lc3b_pkg::reg_idx_t i_src1,
	input lc3b_pkg::reg_idx_t i_src2,
	output lc3b_pkg::word_t o_sr1_val,
	output lc3b_pkg::word_t o_sr2_val,
	output lc3b_pkg::cc_t o_cc
);
	import lc3b_pkg::*;

	word_t regs [NUM_REGS];
	cc_t cc;
	cc_t wb_cc;

	always_comb
	begin
		if (wb.data[WORD_W-1])
			wb_cc = CC_N;
		else if (wb.data == '0)
			wb_cc = CC_Z;
		else
			wb_cc = CC_P;
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			cc <= CC_RESET;
		end
		else if (wb.valid)
		begin
			regs[wb.dest] <= wb.data;
			if (wb.set_cc)
				cc <= wb_cc;
		end
	end

	// Write-before-read bypass
	assign o_sr1_val = (wb.valid && wb.dest == i_src1) ? wb.data : regs[i_src1];
	assign o_sr2_val = (wb.valid && wb.dest == i_src2) ? wb.data : regs[i_src2];

	assign o_cc = cc;

endmodule : reg_file

`default_nettype wire

// File: tb_lc3b_pipe.sv
// Testbench for the LC-3b integer pipeline
// Random program under instruction-port stalls, checked against a
// reference model of the kept instructions
`timescale 1ns/10ps
`default_nettype none

module tb_lc3b_pipe;
	import lc3b_pkg::*;

	localparam int PROG_LEN = 120;
	localparam int MEM_WORDS = 1024;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam logic [31:0] RAND_SEED = 32'h39eb_f486;

	logic clk = 1'b0;
	logic i_rst;
	logic i_imem_resp;
	word_t i_imem_rdata;
	word_t o_imem_addr;
	logic o_imem_read;
	logic o_wb_valid;
	reg_idx_t o_wb_dest;
	word_t o_wb_data;
	cc_t o_cc;

	word_t imem [MEM_WORDS];
	word_t model_regs [8];
	cc_t model_cc;
	reg_idx_t exp_dest [$];
	word_t exp_data [$];
	cc_t exp_cc [$];
	int wb_idx;
	cc_t cur_cc;
	logic [31:0] rand_init;
	word_t pc_addr;
	reg_idx_t gen_dest;
	word_t gen_data;
	cc_t gen_cc;

	always #(CLK_PERIOD / 2) clk = ~clk;

	lc3b_pipe lc3b_pipe_inst
	(
		.clk,
		.i_rst,
		.i_imem_resp,
		.i_imem_rdata,
		.o_imem_addr,
		.o_imem_read,
		.o_wb_valid,
		.o_wb_dest,
		.o_wb_data,
		.o_cc
	);

	bind lc3b_pipe lc3b_pipe_assert lc3b_pipe_assert_inst
	(
		.clk(clk),
		.i_rst(i_rst),
		.o_imem_addr(o_imem_addr),
		.o_wb_valid(o_wb_valid),
		.o_wb_dest(o_wb_dest),
		.o_wb_data(o_wb_data),
		.o_cc(o_cc)
	);

	// Memory answers combinationally
	assign i_imem_rdata = imem[o_imem_addr[10:1]];

	// Withhold the response on about a quarter of cycles
	always @(posedge clk)
	begin
		#1;
		i_imem_resp = ($urandom % 4) != 0;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Failures of the bound port assertions
	always @(lc3b_pipe_inst.lc3b_pipe_assert_inst.fail_count)
	begin
		if (lc3b_pipe_inst.lc3b_pipe_assert_inst.fail_count != 0)
			report_failure("A port assertion on the DUT failed");
	end

	function automatic cc_t cc_of(input word_t v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		return 3'b001;
	endfunction

	// Runs one instruction on the model state and returns 1 on a writeback
	function automatic bit model_exec(input word_t ir, input word_t addr,
		output reg_idx_t dest, output word_t data, output cc_t cc);
		word_t a;
		word_t b;
		logic [31:0] wide;
		bit writes;
		a = model_regs[ir[8:6]];
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
		wide = {{16{a[15]}}, a} >> ir[3:0];
		dest = ir[11:9];
		data = 16'h0000;
		writes = 1'b1;
		case (ir[15:12])
			4'b0001: data = a + b;
			4'b0101: data = a & b;
			4'b1001: data = ~a;
			4'b1101:
			begin
				if (!ir[4])
					data = a << ir[3:0];
				else if (ir[5])
					data = wide[15:0];
				else
					data = a >> ir[3:0];
			end
			4'b1110: data = addr + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
			default: writes = 1'b0;
		endcase
		// LEA keeps the old cc
		cc = (writes && ir[15:12] != 4'b1110) ? cc_of(data) : model_cc;
		return writes;
	endfunction

	function automatic bit is_kept(input logic [3:0] op);
		return op == 4'b0001 || op == 4'b0101 || op == 4'b1001 || op == 4'b1101
			|| op == 4'b1110;
	endfunction

	// Registers 0 to 3 only, so dependences are frequent
	function automatic word_t random_instr();
		logic [31:0] rnd;
		int kind;
		reg_idx_t dr;
		reg_idx_t sr1;
		reg_idx_t sr2;
		logic [3:0] op;
		kind = $urandom % 10;
		rnd = $urandom;
		dr = {1'b0, rnd[17:16]};
		sr1 = {1'b0, rnd[19:18]};
		sr2 = {1'b0, rnd[21:20]};
		op = rnd[31:28];
		case (kind)
			0, 1, 9: return {4'b0001, dr, sr1, rnd[5], rnd[5] ? rnd[4:0] : {2'b00, sr2}};
			2, 3: return {4'b0101, dr, sr1, rnd[5], rnd[5] ? rnd[4:0] : {2'b00, sr2}};
			4: return {4'b1001, dr, sr1, 6'b111111};
			5, 6: return {4'b1101, dr, sr1, rnd[5:0]};
			7: return {4'b1110, dr, rnd[8:0]};
			default:
			begin
				while (is_kept(op))
				begin
					rnd = $urandom;
					op = rnd[3:0];
				end
				return {op, rnd[15:4]};
			end
		endcase
	endfunction

	task automatic sample_writeback();
		@(negedge clk);
		check_value("o_imem_read", {15'b0, o_imem_read}, 16'h0001);
		check_value("o_cc", {13'b0, o_cc}, {13'b0, cur_cc});
		if (o_wb_valid)
		begin
			if (wb_idx >= exp_data.size())
				report_failure("A writeback arrived after every instruction had retired");
			else
			begin
				check_value("o_wb_dest", {13'b0, o_wb_dest}, {13'b0, exp_dest[wb_idx]});
				check_value("o_wb_data", o_wb_data, exp_data[wb_idx]);
				cur_cc = exp_cc[wb_idx];
				wb_idx++;
			end
		end
	endtask

	initial
	begin
		rand_init = $urandom(RAND_SEED);
		i_rst = 1'b1;
		i_imem_resp = 1'b0;
		model_cc = CC_RESET;
		for (int i = 0; i < 8; i++)
			model_regs[i] = 16'h0000;
		// JMP words beyond the program decode as bubbles
		for (int i = 0; i < MEM_WORDS; i++)
			imem[i] = {4'hC, i[11:0]};
		pc_addr = RESET_PC;
		for (int i = 0; i < PROG_LEN; i++)
		begin
			imem[i] = random_instr();
			if (model_exec(imem[i], pc_addr, gen_dest, gen_data, gen_cc))
			begin
				exp_dest.push_back(gen_dest);
				exp_data.push_back(gen_data);
				exp_cc.push_back(gen_cc);
				model_regs[gen_dest] = gen_data;
				model_cc = gen_cc;
			end
			pc_addr = pc_addr + PC_STEP;
		end

		repeat (RESET_CYCLES)
		begin
			@(posedge clk);
			#1;
			check_value("o_wb_valid", {15'b0, o_wb_valid}, 16'h0000);
			check_value("o_imem_read", {15'b0, o_imem_read}, 16'h0000);
			check_value("o_imem_addr", o_imem_addr, RESET_PC);
			check_value("o_cc", {13'b0, o_cc}, {13'b0, CC_RESET});
		end
		i_rst = 1'b0;
		// Read enable rises at the first edge out of reset
		@(posedge clk);
		#1;

		cur_cc = CC_RESET;
		wb_idx = 0;
		while (wb_idx < exp_data.size())
			sample_writeback();
		// Only bubbles remain to drain
		repeat (8)
			sample_writeback();
		$display("All tests passed");
		$finish;
	end

	initial
	begin
		#((PROG_LEN * 4 + 50) * CLK_PERIOD);
		report_failure("Timeout: the pipeline did not retire every instruction in time");
	end

endmodule : tb_lc3b_pipe

`default_nettype wire
